// File: bench/simd_alu_props.sv
// Handshake timing properties for the SIMD ALU
// Bound into the top level

`timescale 1ns/100ps

module simd_alu_props (
  input logic clk_i,
  input logic arst_n_i,
  input logic op_valid_i,
  input logic valid_i,
  input logic ov_i
);

  logic strobe_seen;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strobe_seen <= 1'b0;
    end else if (op_valid_i) begin
      strobe_seen <= 1'b1;
    end
  end

  idle_until_strobe: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !strobe_seen |-> !valid_i
  ) else $error("valid_o high before the first strobe");

  valid_after_strobe: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) op_valid_i |=> valid_i
  ) else $error("valid_o missing one cycle after op_valid_i");

  // Exactly one cycle, never without a strobe
  no_stray_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !op_valid_i |=> !valid_i
  ) else $error("valid_o high without a strobe in the cycle before");

  ov_only_when_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) ov_i |-> valid_i
  ) else $error("ov_o high outside a valid cycle");

endmodule

bind simd_alu simd_alu_props i_simd_alu_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .op_valid_i (op_valid_i),
  .valid_i    (valid_o),
  .ov_i       (ov_o)
);

// File: bench/simd_alu_tb.sv
// Testbench for the packed-SIMD ALU
// Reads vectors from a text file, strobes each one into the DUT and
// checks the registered result and overflow flag

`timescale 1ns/100ps

module simd_alu_tb;

  localparam int    CLK_PERIOD     = 40;
  localparam int    RESET_CYCLES   = 4;
  localparam int    RESULT_TIMEOUT = 4;
  localparam string TEST_FILE      = "bench/simd_alu_tests.txt";

  typedef struct packed {
    simd_alu_pkg::simd_op_e op;
    simd_alu_pkg::word_t    a;
    simd_alu_pkg::word_t    b;
    simd_alu_pkg::word_t    result;
    logic                   ov;
    logic                   burst;
  } test_vec_t;

  logic                   clk;
  logic                   arst_n;
  logic                   op_valid;
  simd_alu_pkg::simd_op_e op;
  simd_alu_pkg::word_t    operand_a;
  simd_alu_pkg::word_t    operand_b;
  simd_alu_pkg::word_t    result;
  logic                   valid;
  logic                   ov;

  test_vec_t tests[$];
  int        pending[$];
  int        pass_count;
  int        fail_count;
  bit        tests_loaded;

  simd_alu i_simd_alu (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .result_o    (result),
    .valid_o     (valid),
    .ov_o        (ov)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Vector file
  ////////////////////
  task automatic load_tests(output bit ok);
    int                  fd;
    int                  fields;
    int                  op_code;
    int                  ov_val;
    int                  burst_val;
    string               line;
    simd_alu_pkg::word_t a_val;
    simd_alu_pkg::word_t b_val;
    simd_alu_pkg::word_t res_val;
    test_vec_t           tv;
    ok = 1'b0;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      // Lines starting with '#' are comments
      if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != 8'h23) begin
        fields = $sscanf(line, "%d %h %h %h %d %d",
                         op_code, a_val, b_val, res_val, ov_val, burst_val);
        if (fields == 6) begin
          tv.op     = simd_alu_pkg::simd_op_e'(op_code[4:0]);
          tv.a      = a_val;
          tv.b      = b_val;
          tv.result = res_val;
          tv.ov     = ov_val[0];
          tv.burst  = burst_val[0];
          tests.push_back(tv);
        end
      end
    end
    $fclose(fd);
    ok = (tests.size() > 0);
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_result(
    input  int                  idx,
    input  simd_alu_pkg::word_t got,
    input  simd_alu_pkg::word_t exp,
    output bit                  ok
  );
    ok = (got === exp);
    if (!ok) begin
      $display("[ERROR] %0t: test %0d result 0x%08h, expected 0x%08h", $time, idx, got, exp);
    end
  endtask

  task automatic check_ov(input int idx, input logic got, input logic exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("[ERROR] %0t: test %0d ov_o %b, expected %b", $time, idx, got, exp);
    end
  endtask

  // Results are sampled on the falling edge, half a cycle after the update
  task automatic check_output();
    int                     idx;
    bit                     result_ok;
    bit                     ov_ok;
    simd_alu_pkg::simd_op_e op_code;
    if (pending.size() == 0) begin
      $display("valid_o went high at %0t with no operation in flight", $time);
      fail_count++;
    end else begin
      idx     = pending.pop_front();
      op_code = tests[idx].op;
      check_result(idx, result, tests[idx].result, result_ok);
      check_ov(idx, ov, tests[idx].ov, ov_ok);
      if (result_ok && ov_ok) begin
        pass_count++;
        $display("test %0d %s ok", idx, op_code.name());
      end else begin
        fail_count++;
        $display("test %0d %s failed", idx, op_code.name());
      end
    end
  endtask

  always @(negedge clk) begin
    if (arst_n && valid) begin
      check_output();
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic issue_test(input int idx);
    @(posedge clk);
    op_valid  <= 1'b1;
    op        <= tests[idx].op;
    operand_a <= tests[idx].a;
    operand_b <= tests[idx].b;
    pending.push_back(idx);
  endtask

  task automatic wait_for_results();
    int cycles;
    cycles = 0;
    while (pending.size() != 0 && cycles < RESULT_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (pending.size() != 0) begin
      $display("No valid_o for test %0d within %0d cycles of its strobe",
               pending[0], RESULT_TIMEOUT);
      fail_count += pending.size();
      pending.delete();
    end
  endtask

  task automatic report();
    $display("Tests: %0d, passed: %0d, failed: %0d", tests.size(), pass_count, fail_count);
    if (fail_count == 0 && pass_count == tests.size()) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  initial begin : stimulus
    int idx;
    bit load_ok;
    arst_n    = 1'b0;
    op_valid  = 1'b0;
    op        = simd_alu_pkg::ADD8;
    operand_a = '0;
    operand_b = '0;
    load_tests(load_ok);
    if (!load_ok) begin
      $display("Could not read any test vectors from %s", TEST_FILE);
      $display("TEST FAIL");
      $finish;
    end else begin
      tests_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      for (idx = 0; idx < tests.size(); idx++) begin
        issue_test(idx);
        // A burst test goes out on the very next cycle
        if (idx + 1 == tests.size() || !tests[idx + 1].burst) begin
          @(posedge clk);
          op_valid <= 1'b0;
          wait_for_results();
        end
      end
      repeat (2) @(posedge clk);
      report();
    end
  end

  // Watchdog scaled to the number of vectors
  initial begin : watchdog
    int limit;
    wait (tests_loaded);
    limit = (tests.size() + 20) * 4;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, simulation stopped", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: bench/simd_alu_tests.txt
# op(decimal opcode) a(hex) b(hex) result(hex) ov burst
# burst 1 issues the test on the cycle right after the previous one
0 017fff80 01010180 02800000 0 0
1 7fffffff 00010001 80000000 0 1
2 001080ff 0110017f ff007f80 0 1
3 00001234 00010234 ffff1000 0 1
4 7f8010f0 01ff20f0 7f8030e0 1 0
4 40c001ff 3fc0ffff 7f8000fe 0 1
5 70008000 1000ffff 7fff8000 1 0
6 807f0500 01ff0780 807ffe7f 1 0
7 12348000 02340001 10008000 1 0
8 ff801000 017ff000 ffffff00 1 0
9 80001234 80000001 ffff1235 1 0
10 051000ff 0610010f 000000f0 1 0
11 10000001 0fff0000 00010001 0 1
12 7f8001ff 7f8002fe 7f8001fe 0 0
13 7fff8000 0001ffff 4000bfff 0 1
14 807f0300 7f800101 807f01ff 0 0
15 80000005 7fff0008 8000fffe 0 0
16 12345678 12005679 ff00ff00 0 0
17 1234abcd 1234abcc ffff0000 0 0
18 807fff01 7f800001 ff00ff00 0 0
19 80000001 7fffffff ffff0000 0 1
20 807f00ff 7f8001ff 00ffff00 0 0
21 80000001 7fff0100 0000ffff 0 0
22 807f05fe 7f800501 808005fe 0 0
23 80001234 7fff1235 80001234 0 0
24 807f05fe 7f800601 7f7f0601 0 0
25 ffff0100 000100ff 00010100 0 0
26 807f00ff 7f8001fe 7f7f00fe 0 0
27 800000ff 7fff0100 7fff00ff 0 0
28 807f00ff 7f8001fe 808001ff 0 1
29 ffff0000 0000ffff ffffffff 0 1

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SIMD ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module simd_alu_tb \
  -o simd_alu_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/simd_alu_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulator exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"

// File: src.f
src/simd_alu_pkg.sv
src/simd_lane_adder.sv
src/simd_saturate.sv
src/simd_compare.sv
src/simd_alu.sv
bench/simd_alu_props.sv
bench/simd_alu_tb.sv

// File: src/simd_alu.sv
// Packed-SIMD arithmetic unit, top level
// Decodes the opcode, muxes the lane results and registers them one cycle
// after the op_valid_i strobe

`timescale 1ns/100ps

module simd_alu (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   op_valid_i,
  input  simd_alu_pkg::simd_op_e op_i,
  input  simd_alu_pkg::word_t    operand_a_i,
  input  simd_alu_pkg::word_t    operand_b_i,
  output simd_alu_pkg::word_t    result_o,
  output logic                   valid_o,
  output logic                   ov_o
);

  simd_alu_pkg::simd_ctrl_t ctrl;
  simd_alu_pkg::lane_sum_t  lane_sum;
  simd_alu_pkg::word_t      sat_word;
  simd_alu_pkg::word_t      half_word;
  simd_alu_pkg::word_t      cmp_word;
  simd_alu_pkg::word_t      minmax_word;
  simd_alu_pkg::word_t      result_d;
  logic                     sat_ov;

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    ctrl.width      = simd_alu_pkg::W8;
    ctrl.sub        = 1'b0;
    ctrl.signed_ops = 1'b0;
    ctrl.cmp_kind   = 2'b00;
    ctrl.max_sel    = 1'b0;
    ctrl.sel        = simd_alu_pkg::PLAIN;

    unique case (op_i)
      simd_alu_pkg::ADD16,   simd_alu_pkg::SUB16,    simd_alu_pkg::KADD16,
      simd_alu_pkg::KSUB16,  simd_alu_pkg::UKADD16,  simd_alu_pkg::UKSUB16,
      simd_alu_pkg::RADD16,  simd_alu_pkg::RSUB16,   simd_alu_pkg::CMPEQ16,
      simd_alu_pkg::SCMPLT16, simd_alu_pkg::UCMPLT16, simd_alu_pkg::SMIN16,
      simd_alu_pkg::SMAX16,  simd_alu_pkg::UMIN16,   simd_alu_pkg::UMAX16:
        ctrl.width = simd_alu_pkg::W16;
      default: ;
    endcase

    // Compares and min/max all run as a subtraction
    unique case (op_i)
      simd_alu_pkg::SUB8, simd_alu_pkg::SUB16: begin
        ctrl.sub = 1'b1;
      end
      simd_alu_pkg::KADD8, simd_alu_pkg::KADD16: begin
        ctrl.signed_ops = 1'b1;
        ctrl.sel        = simd_alu_pkg::SAT;
      end
      simd_alu_pkg::KSUB8, simd_alu_pkg::KSUB16: begin
        ctrl.sub        = 1'b1;
        ctrl.signed_ops = 1'b1;
        ctrl.sel        = simd_alu_pkg::SAT;
      end
      simd_alu_pkg::UKADD8, simd_alu_pkg::UKADD16: begin
        ctrl.sel = simd_alu_pkg::SAT;
      end
      simd_alu_pkg::UKSUB8, simd_alu_pkg::UKSUB16: begin
        ctrl.sub = 1'b1;
        ctrl.sel = simd_alu_pkg::SAT;
      end
      simd_alu_pkg::RADD8, simd_alu_pkg::RADD16: begin
        ctrl.signed_ops = 1'b1;
        ctrl.sel        = simd_alu_pkg::HALF;
      end
      simd_alu_pkg::RSUB8, simd_alu_pkg::RSUB16: begin
        ctrl.sub        = 1'b1;
        ctrl.signed_ops = 1'b1;
        ctrl.sel        = simd_alu_pkg::HALF;
      end
      simd_alu_pkg::CMPEQ8, simd_alu_pkg::CMPEQ16: begin
        ctrl.sub = 1'b1;
        ctrl.sel = simd_alu_pkg::CMP;
      end
      simd_alu_pkg::SCMPLT8, simd_alu_pkg::SCMPLT16: begin
        ctrl.sub        = 1'b1;
        ctrl.signed_ops = 1'b1;
        ctrl.cmp_kind   = 2'b01;
        ctrl.sel        = simd_alu_pkg::CMP;
      end
      simd_alu_pkg::UCMPLT8, simd_alu_pkg::UCMPLT16: begin
        ctrl.sub      = 1'b1;
        ctrl.cmp_kind = 2'b01;
        ctrl.sel      = simd_alu_pkg::CMP;
      end
      simd_alu_pkg::SMIN8, simd_alu_pkg::SMIN16,
      simd_alu_pkg::SMAX8, simd_alu_pkg::SMAX16: begin
        ctrl.sub        = 1'b1;
        ctrl.signed_ops = 1'b1;
        ctrl.max_sel    = (op_i == simd_alu_pkg::SMAX8) || (op_i == simd_alu_pkg::SMAX16);
        ctrl.sel        = simd_alu_pkg::MINMAX;
      end
      simd_alu_pkg::UMIN8, simd_alu_pkg::UMIN16,
      simd_alu_pkg::UMAX8, simd_alu_pkg::UMAX16: begin
        ctrl.sub     = 1'b1;
        ctrl.max_sel = (op_i == simd_alu_pkg::UMAX8) || (op_i == simd_alu_pkg::UMAX16);
        ctrl.sel     = simd_alu_pkg::MINMAX;
      end
      default: ;
    endcase
  end

  ////////////////////
  // Datapath
  ////////////////////
  simd_lane_adder i_simd_lane_adder (
    .a_i    (operand_a_i),
    .b_i    (operand_b_i),
    .ctrl_i (ctrl),
    .sum_o  (lane_sum)
  );

  simd_saturate i_simd_saturate (
    .sum_i  (lane_sum),
    .ctrl_i (ctrl),
    .sat_o  (sat_word),
    .half_o (half_word),
    .ov_o   (sat_ov)
  );

  simd_compare i_simd_compare (
    .a_i      (operand_a_i),
    .b_i      (operand_b_i),
    .sum_i    (lane_sum),
    .ctrl_i   (ctrl),
    .cmp_o    (cmp_word),
    .minmax_o (minmax_word)
  );

  always_comb begin
    unique case (ctrl.sel)
      simd_alu_pkg::SAT:    result_d = sat_word;
      simd_alu_pkg::HALF:   result_d = half_word;
      simd_alu_pkg::CMP:    result_d = cmp_word;
      simd_alu_pkg::MINMAX: result_d = minmax_word;
      default:              result_d = lane_sum.sum;
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////
  // Result holds between strobes, overflow only flags its own valid cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      ov_o     <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= op_valid_i;
      ov_o    <= op_valid_i & sat_ov;
      if (op_valid_i) begin
        result_o <= result_d;
      end
    end
  end

endmodule

// File: src/simd_alu_pkg.sv
// Packed-SIMD ALU shared definitions
// Opcodes, lane width, decoded control, adder result and saturation limits

package simd_alu_pkg;

  localparam int unsigned BYTES_PER_WORD = 4;

  typedef logic [31:0] word_t;

  ////////////////////
  // Opcodes
  ////////////////////
  // Numeric order is shared with the test vectors
  typedef enum logic [4:0] {
    ADD8,
    ADD16,
    SUB8,
    SUB16,
    KADD8,
    KADD16,
    KSUB8,
    KSUB16,
    UKADD8,
    UKADD16,
    UKSUB8,
    UKSUB16,
    RADD8,
    RADD16,
    RSUB8,
    RSUB16,
    CMPEQ8,
    CMPEQ16,
    SCMPLT8,
    SCMPLT16,
    UCMPLT8,
    UCMPLT16,
    SMIN8,
    SMIN16,
    SMAX8,
    SMAX16,
    UMIN8,
    UMIN16,
    UMAX8,
    UMAX16
  } simd_op_e;

  typedef enum logic {
    W8,
    W16
  } lane_width_e;

  typedef enum logic [2:0] {
    PLAIN,
    SAT,
    HALF,
    CMP,
    MINMAX
  } result_sel_e;

  ////////////////////
  // Datapath structs
  ////////////////////
  // cmp_kind: 00 equal, 01 less, 10 less-or-equal
  typedef struct packed {
    lane_width_e width;
    logic        sub;
    logic        signed_ops;
    logic [1:0]  cmp_kind;
    logic        max_sel;
    result_sel_e sel;
  } simd_ctrl_t;

  // ext holds bit 8 of each widened byte sum
  typedef struct packed {
    word_t      sum;
    logic [3:0] ext;
  } lane_sum_t;

  // Saturation limits
  localparam logic [7:0]  SAT_S8_MAX  = 8'h7f;
  localparam logic [7:0]  SAT_S8_MIN  = 8'h80;
  localparam logic [15:0] SAT_S16_MAX = 16'h7fff;
  localparam logic [15:0] SAT_S16_MIN = 16'h8000;
  localparam logic [7:0]  SAT_U8_MAX  = 8'hff;
  localparam logic [15:0] SAT_U16_MAX = 16'hffff;

endpackage

// File: src/simd_compare.sv
// Per-lane compare and min/max selection
// Flags come from the adder's subtraction: zero sum and widened sign

`timescale 1ns/100ps

module simd_compare (
  input  simd_alu_pkg::word_t      a_i,
  input  simd_alu_pkg::word_t      b_i,
  input  simd_alu_pkg::lane_sum_t  sum_i,
  input  simd_alu_pkg::simd_ctrl_t ctrl_i,
  output simd_alu_pkg::word_t      cmp_o,
  output simd_alu_pkg::word_t      minmax_o
);

  logic [3:0] byte_zero;
  logic [3:0] is_equal;
  logic [3:0] is_less;
  logic [3:0] cmp_flag;
  logic [3:0] pick_a;

  always_comb begin
    for (int i = 0; i < simd_alu_pkg::BYTES_PER_WORD; i++) begin
      byte_zero[i] = (sum_i.sum[8*i +: 8] == 8'h00);
    end
  end

  ////////////////////
  // Lane flags
  ////////////////////
  // 16-bit lanes spread their flag over both bytes
  always_comb begin
    if (ctrl_i.width == simd_alu_pkg::W8) begin
      is_equal = byte_zero;
      is_less  = sum_i.ext;
    end else begin
      is_equal = {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
      is_less  = {{2{sum_i.ext[3]}}, {2{sum_i.ext[1]}}};
    end
  end

  always_comb begin
    unique case (ctrl_i.cmp_kind)
      2'b01:   cmp_flag = is_less;
      default: cmp_flag = is_equal;
    endcase
  end

  // Max keeps A where A is not less than B
  assign pick_a = is_less ^ {4{ctrl_i.max_sel}};

  ////////////////////
  // Outputs
  ////////////////////
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::BYTES_PER_WORD; i++) begin
      cmp_o[8*i +: 8]    = {8{cmp_flag[i]}};
      minmax_o[8*i +: 8] = pick_a[i] ? a_i[8*i +: 8] : b_i[8*i +: 8];
    end
  end

endmodule

// File: src/simd_lane_adder.sv
// Lane-partitioned adder
// Four 9-bit byte adders, chained in pairs for 16-bit lanes, with
// sign or zero extension so bit 8 of each lane carries its true sign

`timescale 1ns/100ps

module simd_lane_adder (
  input  simd_alu_pkg::word_t      a_i,
  input  simd_alu_pkg::word_t      b_i,
  input  simd_alu_pkg::simd_ctrl_t ctrl_i,
  output simd_alu_pkg::lane_sum_t  sum_o
);

  logic            wide;
  logic [3:0]      lane_top;
  logic [3:0]      chain;
  logic [3:0][8:0] opnd_a;
  logic [3:0][8:0] opnd_b;
  logic [3:0][8:0] byte_sum;

  assign wide = (ctrl_i.width == simd_alu_pkg::W16);

  // Bytes holding the top of a lane
  assign lane_top = wide ? 4'b1010 : 4'b1111;

  // Bytes fed by the carry of the byte below
  assign chain = wide ? 4'b1010 : 4'b0000;

  ////////////////////
  // Operand prep
  ////////////////////
  // Only the top byte of a lane gets the extension bit,
  // lower bytes stay at 8 bits so bit 8 is a clean carry
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::BYTES_PER_WORD; i++) begin
      opnd_a[i] = {lane_top[i] & ctrl_i.signed_ops & a_i[8*i+7], a_i[8*i +: 8]};
      opnd_b[i] = {lane_top[i] & ((ctrl_i.signed_ops & b_i[8*i+7]) ^ ctrl_i.sub),
                   b_i[8*i +: 8] ^ {8{ctrl_i.sub}}};
    end
  end

  ////////////////////
  // Byte adders
  ////////////////////
  always_comb begin
    logic carry;
    logic cin;
    carry = 1'b0;
    for (int i = 0; i < simd_alu_pkg::BYTES_PER_WORD; i++) begin
      // Lane start takes the subtract carry-in, otherwise the chained carry
      cin         = chain[i] ? carry : ctrl_i.sub;
      byte_sum[i] = opnd_a[i] + opnd_b[i] + {8'h00, cin};
      carry       = byte_sum[i][8];
    end
  end

  always_comb begin
    for (int i = 0; i < simd_alu_pkg::BYTES_PER_WORD; i++) begin
      sum_o.sum[8*i +: 8] = byte_sum[i][7:0];
      sum_o.ext[i]        = byte_sum[i][8];
    end
  end

endmodule

// File: src/simd_saturate.sv
// Saturating and halving result generation
// Clamps overflowing lanes and forms the averaged sum, plus the overflow flag

`timescale 1ns/100ps

module simd_saturate (
  input  simd_alu_pkg::lane_sum_t  sum_i,
  input  simd_alu_pkg::simd_ctrl_t ctrl_i,
  output simd_alu_pkg::word_t      sat_o,
  output simd_alu_pkg::word_t      half_o,
  output logic                     ov_o
);

  logic [3:0]          ovf8;
  logic [1:0]          ovf16;
  simd_alu_pkg::word_t sat8;
  simd_alu_pkg::word_t sat16;
  simd_alu_pkg::word_t half8;
  simd_alu_pkg::word_t half16;
  logic                lane_ov;

  ////////////////////
  // Byte lanes
  ////////////////////
  always_comb begin
    logic [7:0] clamp;
    for (int i = 0; i < simd_alu_pkg::BYTES_PER_WORD; i++) begin
      if (ctrl_i.signed_ops) begin
        // Extension and top bit disagree on overflow
        ovf8[i] = sum_i.ext[i] ^ sum_i.sum[8*i+7];
        clamp   = sum_i.ext[i] ? simd_alu_pkg::SAT_S8_MIN : simd_alu_pkg::SAT_S8_MAX;
      end else begin
        // Carry on add, borrow on subtract
        ovf8[i] = sum_i.ext[i];
        clamp   = ctrl_i.sub ? 8'h00 : simd_alu_pkg::SAT_U8_MAX;
      end
      sat8[8*i +: 8]  = ovf8[i] ? clamp : sum_i.sum[8*i +: 8];
      half8[8*i +: 8] = {sum_i.ext[i], sum_i.sum[8*i+1 +: 7]};
    end
  end

  ////////////////////
  // Halfword lanes
  ////////////////////
  // Extension comes from the upper byte of each halfword
  always_comb begin
    logic [15:0] clamp;
    for (int j = 0; j < simd_alu_pkg::BYTES_PER_WORD / 2; j++) begin
      if (ctrl_i.signed_ops) begin
        ovf16[j] = sum_i.ext[2*j+1] ^ sum_i.sum[16*j+15];
        clamp    = sum_i.ext[2*j+1] ? simd_alu_pkg::SAT_S16_MIN : simd_alu_pkg::SAT_S16_MAX;
      end else begin
        ovf16[j] = sum_i.ext[2*j+1];
        clamp    = ctrl_i.sub ? 16'h0000 : simd_alu_pkg::SAT_U16_MAX;
      end
      sat16[16*j +: 16]  = ovf16[j] ? clamp : sum_i.sum[16*j +: 16];
      half16[16*j +: 16] = {sum_i.ext[2*j+1], sum_i.sum[16*j+1 +: 15]};
    end
  end

  assign sat_o   = (ctrl_i.width == simd_alu_pkg::W8) ? sat8 : sat16;
  assign half_o  = (ctrl_i.width == simd_alu_pkg::W8) ? half8 : half16;
  assign lane_ov = (ctrl_i.width == simd_alu_pkg::W8) ? |ovf8 : |ovf16;

  // Flag only for saturating ops
  assign ov_o = lane_ov & (ctrl_i.sel == simd_alu_pkg::SAT);

endmodule
